//--- rtl/mipsPkg.sv
`default_nettype none

package mipsPkg;

    localparam logic [5:0] OP_R   = 6'b000000;
    localparam logic [5:0] OP_ORI = 6'b001101;
    localparam logic [5:0] OP_SW  = 6'b101011;
    localparam logic [5:0] OP_LW  = 6'b100011;
    localparam logic [5:0] OP_BEQ = 6'b000100;
    localparam logic [5:0] OP_LUI = 6'b001111;
    localparam logic [5:0] OP_JAL = 6'b000011;

    localparam logic [5:0] FUNC_ADD = 6'b100000;
    localparam logic [5:0] FUNC_SUB = 6'b100010;
    localparam logic [5:0] FUNC_JR  = 6'b001000;

    localparam logic [31:0] RESET_PC = 32'h0000_0000;

    typedef enum logic [1:0] {
        ALU_ADD = 2'd0,
        ALU_SUB = 2'd1,
        ALU_OR  = 2'd2
    } aluOpT;

    typedef enum logic [1:0] {
        EXT_ZERO  = 2'd0,
        EXT_SIGN  = 2'd1,
        EXT_UPPER = 2'd2
    } extOpT;

    // Write-back data source.
    typedef enum logic [1:0] {
        WD_MEM  = 2'd0,
        WD_LINK = 2'd1,
        WD_IMM  = 2'd2,
        WD_ALU  = 2'd3
    } wdSrcT;

    typedef enum logic [1:0] {
        FWD_RF = 2'd0,
        FWD_M  = 2'd1,
        FWD_W  = 2'd2
    } fwdSelT;

    typedef struct packed {
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] a3;
        logic       regWrite;
        logic       memWrite;
        logic       memToReg;
        logic       aluSrcImm;
        logic       branch;
        logic       jr;
        logic       jal;
        logic       useInE;
        logic       newInE;
        aluOpT      aluOp;
        extOpT      extOp;
        wdSrcT      wdSrc;
    } ctrlT;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] instr;
    } ifIdT;

    typedef struct packed {
        ctrlT        ctrl;
        logic [31:0] pc;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] immExt;
    } idExT;

    typedef struct packed {
        ctrlT        ctrl;
        logic [31:0] pc;
        logic [31:0] aluOut;
        logic [31:0] b;
        logic [31:0] immExt;
    } exMemT;

    typedef struct packed {
        ctrlT        ctrl;
        logic [31:0] pc;
        logic [31:0] aluOut;
        logic [31:0] memData;
        logic [31:0] immExt;
    } memWbT;

endpackage

`default_nettype wire

//--- rtl/memReqIf.sv
`default_nettype none

// One data access at a time between the M stage and the bus master.
interface memReqIf;

    logic        req;
    logic        we;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] rdata;
    logic        done;

    modport core (
        output req,
        output we,
        output addr,
        output wdata,
        input  rdata,
        input  done
    );

    modport bus (
        input  req,
        input  we,
        input  addr,
        input  wdata,
        output rdata,
        output done
    );

endinterface

`default_nettype wire

//--- rtl/ctrlDecode.sv
`default_nettype none

module ctrlDecode
    import mipsPkg::*;
(
    input  logic [31:0] instr,
    output ctrlT        ctrl,
    output logic [15:0] imm,
    output logic [25:0] instrIndex
);

    logic [5:0] opcode;
    logic [5:0] funct;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic isAdd, isSub, isJr;
    logic isOri, isLw, isSw;
    logic isBeq, isLui, isJal;
    logic useRs;
    logic useRt;

    assign opcode     = instr[31:26];
    assign funct      = instr[5:0];
    assign rs         = instr[25:21];
    assign rt         = instr[20:16];
    assign rd         = instr[15:11];
    assign imm        = instr[15:0];
    assign instrIndex = instr[25:0];

    assign isAdd = (opcode == OP_R) && (funct == FUNC_ADD);
    assign isSub = (opcode == OP_R) && (funct == FUNC_SUB);
    assign isJr  = (opcode == OP_R) && (funct == FUNC_JR);
    assign isOri = (opcode == OP_ORI);
    assign isLw  = (opcode == OP_LW);
    assign isSw  = (opcode == OP_SW);
    assign isBeq = (opcode == OP_BEQ);
    assign isLui = (opcode == OP_LUI);
    assign isJal = (opcode == OP_JAL);

    // Unused source fields read as r0 so they never raise a hazard.
    assign useRs = isAdd | isSub | isOri | isLw | isSw | isBeq | isJr;
    assign useRt = isAdd | isSub | isSw | isBeq;

    always_comb begin
        ctrl    = '0;
        ctrl.rs = useRs ? rs : 5'd0;
        ctrl.rt = useRt ? rt : 5'd0;
        if (isAdd || isSub) begin
            ctrl.a3 = rd;
        end else if (isOri || isLui || isLw) begin
            ctrl.a3 = rt;
        end else if (isJal) begin
            ctrl.a3 = 5'd31;
        end
        ctrl.regWrite  = isAdd | isSub | isOri | isLw | isLui | isJal;
        ctrl.memWrite  = isSw;
        ctrl.memToReg  = isLw;
        ctrl.aluSrcImm = isOri | isLui | isLw | isSw;
        ctrl.branch    = isBeq;
        ctrl.jr        = isJr;
        ctrl.jal       = isJal;
        ctrl.useInE    = isAdd | isSub | isOri | isLw | isSw;
        // lui and jal results are known in D already.
        ctrl.newInE    = isAdd | isSub | isOri;
        if (isSub) begin
            ctrl.aluOp = ALU_SUB;
        end else if (isOri) begin
            ctrl.aluOp = ALU_OR;
        end
        if (isLui) begin
            ctrl.extOp = EXT_UPPER;
        end else if (isLw || isSw || isBeq) begin
            ctrl.extOp = EXT_SIGN;
        end
        if (isLw) begin
            ctrl.wdSrc = WD_MEM;
        end else if (isJal) begin
            ctrl.wdSrc = WD_LINK;
        end else if (isLui) begin
            ctrl.wdSrc = WD_IMM;
        end else begin
            ctrl.wdSrc = WD_ALU;
        end
    end

endmodule

`default_nettype wire

//--- rtl/regFile.sv
`default_nettype none

module regFile (
    input  logic        clk,
    input  logic        reset,
    input  logic [4:0]  ra1,
    input  logic [4:0]  ra2,
    output logic [31:0] rd1,
    output logic [31:0] rd2,
    input  logic        we,
    input  logic [4:0]  wa,
    input  logic [31:0] wd
);

    logic [31:0] regs [32];
    logic        writing;

    assign writing = we && (wa != 5'd0);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (writing) begin
            regs[wa] <= wd;
        end
    end

    // Write-before-read bypass.
    assign rd1 = (writing && (wa == ra1)) ? wd : regs[ra1];
    assign rd2 = (writing && (wa == ra2)) ? wd : regs[ra2];

    assert property (@(posedge clk) disable iff (reset) we |-> !$isunknown(wa));

endmodule

`default_nettype wire

//--- rtl/hazardUnit.sv
`default_nettype none

module hazardUnit
    import mipsPkg::*;
(
    input  ctrlT   dCtrl,
    input  ctrlT   eCtrl,
    input  ctrlT   mCtrl,
    input  ctrlT   wCtrl,
    output logic   stall,
    output fwdSelT fwdDA,
    output fwdSelT fwdDB,
    output fwdSelT fwdEA,
    output fwdSelT fwdEB
);

    logic stallDUse;
    logic stallEUse;

    function automatic logic writes(ctrlT c, logic [4:0] r);
        return c.regWrite && (c.a3 != 5'd0) && (c.a3 == r);
    endfunction

    // Loads in M have no data yet.
    function automatic fwdSelT pick(logic [4:0] r, ctrlT m, ctrlT w);
        if (writes(m, r) && !m.memToReg) begin
            return FWD_M;
        end else if (writes(w, r)) begin
            return FWD_W;
        end
        return FWD_RF;
    endfunction

    assign fwdDA = pick(dCtrl.rs, mCtrl, wCtrl);
    assign fwdDB = pick(dCtrl.rt, mCtrl, wCtrl);
    assign fwdEA = pick(eCtrl.rs, mCtrl, wCtrl);
    assign fwdEB = pick(eCtrl.rt, mCtrl, wCtrl);

    // Branch and jr operands are needed in D itself.
    assign stallDUse = !dCtrl.useInE &&
                       (writes(eCtrl, dCtrl.rs) || writes(eCtrl, dCtrl.rt) ||
                        (mCtrl.memToReg &&
                         (writes(mCtrl, dCtrl.rs) || writes(mCtrl, dCtrl.rt))));

    assign stallEUse = dCtrl.useInE && eCtrl.memToReg &&
                       (writes(eCtrl, dCtrl.rs) || writes(eCtrl, dCtrl.rt));

    assign stall = stallDUse || stallEUse;

endmodule

`default_nettype wire

//--- rtl/pipeReg.sv
`default_nettype none

module pipeReg #(
    parameter type T = logic [31:0]
) (
    input  logic clk,
    input  logic reset,
    input  logic en,
    input  logic flush,
    input  T     d,
    output T     q
);

    // An all-zero word is a bubble with no writes.
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            q <= '0;
        end else if (en) begin
            q <= d;
        end
    end

endmodule

`default_nettype wire

//--- rtl/cpuCore.sv
`default_nettype none

module cpuCore
    import mipsPkg::*;
(
    input  logic        clk,
    input  logic        reset,
    output logic [31:0] instrAddr,
    input  logic [31:0] instrData,
    memReqIf.core       mem
);

    logic [31:0] pc;
    logic [31:0] pcNext;
    logic        stall;
    logic        memWait;
    ifIdT        fetchD;
    ifIdT        ifId;
    idExT        decodeD;
    idExT        idEx;
    exMemT       exD;
    exMemT       exMem;
    memWbT       memD;
    memWbT       memWb;
    ctrlT        dCtrl;
    logic [15:0] imm;
    logic [25:0] instrIndex;
    logic [31:0] immExt;
    logic [31:0] rfA, rfB;
    logic [31:0] dA, dB;
    logic [31:0] pcPlus4D;
    logic        branchTaken;
    fwdSelT      fwdDA, fwdDB, fwdEA, fwdEB;
    logic [31:0] eA, eB;
    logic [31:0] aluB;
    logic [31:0] aluOut;
    logic [31:0] mResult;
    logic [31:0] wData;

    function automatic logic [31:0] fwdMux(fwdSelT sel, logic [31:0] base,
                                           logic [31:0] mVal, logic [31:0] wVal);
        case (sel)
            FWD_M:   return mVal;
            FWD_W:   return wVal;
            default: return base;
        endcase
    endfunction

    // Fetch.
    assign instrAddr    = pc;
    assign fetchD.pc    = pc;
    assign fetchD.instr = instrData;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= RESET_PC;
        end else if (!stall && !memWait) begin
            pc <= pcNext;
        end
    end

    pipeReg #(.T(ifIdT)) ifIdReg (
        .clk(clk), .reset(reset), .en(!stall && !memWait), .flush(1'b0),
        .d(fetchD), .q(ifId)
    );

    // Decode, with branch and jump resolution.
    ctrlDecode decoder (
        .instr(ifId.instr), .ctrl(dCtrl), .imm(imm), .instrIndex(instrIndex)
    );

    regFile regs (
        .clk(clk), .reset(reset),
        .ra1(dCtrl.rs), .ra2(dCtrl.rt), .rd1(rfA), .rd2(rfB),
        .we(memWb.ctrl.regWrite), .wa(memWb.ctrl.a3), .wd(wData)
    );

    hazardUnit hazards (
        .dCtrl(dCtrl), .eCtrl(idEx.ctrl), .mCtrl(exMem.ctrl), .wCtrl(memWb.ctrl),
        .stall(stall),
        .fwdDA(fwdDA), .fwdDB(fwdDB), .fwdEA(fwdEA), .fwdEB(fwdEB)
    );

    always_comb begin
        case (dCtrl.extOp)
            EXT_SIGN:  immExt = {{16{imm[15]}}, imm};
            EXT_UPPER: immExt = {imm, 16'd0};
            default:   immExt = {16'd0, imm};
        endcase
    end

    assign dA          = fwdMux(fwdDA, rfA, mResult, wData);
    assign dB          = fwdMux(fwdDB, rfB, mResult, wData);
    assign pcPlus4D    = ifId.pc + 32'd4;
    assign branchTaken = dCtrl.branch && (dA == dB);

    // The F-stage instruction is the delay slot and always goes ahead.
    always_comb begin
        if (dCtrl.jr) begin
            pcNext = dA;
        end else if (dCtrl.jal) begin
            pcNext = {pcPlus4D[31:28], instrIndex, 2'b00};
        end else if (branchTaken) begin
            pcNext = pcPlus4D + {immExt[29:0], 2'b00};
        end else begin
            pcNext = pc + 32'd4;
        end
    end

    assign decodeD.ctrl   = dCtrl;
    assign decodeD.pc     = ifId.pc;
    assign decodeD.a      = dA;
    assign decodeD.b      = dB;
    assign decodeD.immExt = immExt;

    pipeReg #(.T(idExT)) idExReg (
        .clk(clk), .reset(reset), .en(!memWait), .flush(stall && !memWait),
        .d(decodeD), .q(idEx)
    );

    // Execute.
    assign eA   = fwdMux(fwdEA, idEx.a, mResult, wData);
    assign eB   = fwdMux(fwdEB, idEx.b, mResult, wData);
    assign aluB = idEx.ctrl.aluSrcImm ? idEx.immExt : eB;

    always_comb begin
        case (idEx.ctrl.aluOp)
            ALU_SUB: aluOut = eA - aluB;
            ALU_OR:  aluOut = eA | aluB;
            default: aluOut = eA + aluB;
        endcase
    end

    assign exD.ctrl   = idEx.ctrl;
    assign exD.pc     = idEx.pc;
    assign exD.aluOut = aluOut;
    assign exD.b      = eB;
    assign exD.immExt = idEx.immExt;

    pipeReg #(.T(exMemT)) exMemReg (
        .clk(clk), .reset(reset), .en(!memWait), .flush(1'b0),
        .d(exD), .q(exMem)
    );

    // Memory. Everything holds until the bus master reports done.
    assign mem.req   = exMem.ctrl.memWrite || exMem.ctrl.memToReg;
    assign mem.we    = exMem.ctrl.memWrite;
    assign mem.addr  = exMem.aluOut;
    assign mem.wdata = exMem.b;
    assign memWait   = mem.req && !mem.done;

    always_comb begin
        case (exMem.ctrl.wdSrc)
            WD_LINK: mResult = exMem.pc + 32'd8;
            WD_IMM:  mResult = exMem.immExt;
            default: mResult = exMem.aluOut;
        endcase
    end

    assign memD.ctrl    = exMem.ctrl;
    assign memD.pc      = exMem.pc;
    assign memD.aluOut  = exMem.aluOut;
    assign memD.memData = mem.rdata;
    assign memD.immExt  = exMem.immExt;

    pipeReg #(.T(memWbT)) memWbReg (
        .clk(clk), .reset(reset), .en(!memWait), .flush(1'b0),
        .d(memD), .q(memWb)
    );

    // Write back.
    always_comb begin
        case (memWb.ctrl.wdSrc)
            WD_MEM:  wData = memWb.memData;
            WD_LINK: wData = memWb.pc + 32'd8;
            WD_IMM:  wData = memWb.immExt;
            default: wData = memWb.aluOut;
        endcase
    end

    // Load-use stalls end within two cycles unless the bus is waiting.
    assert property (@(posedge clk) disable iff (reset)
        (stall && !memWait) [*2] |=> !(stall && !memWait));

endmodule

`default_nettype wire

//--- rtl/wbMaster.sv
`default_nettype none

module wbMaster (
    input  logic        clk,
    input  logic        reset,
    memReqIf.bus        mem,
    output logic        wbCyc,
    output logic        wbStb,
    output logic        wbWe,
    output logic [31:0] wbAdr,
    output logic [31:0] wbDatW,
    input  logic [31:0] wbDatR,
    input  logic        wbAck
);

    typedef enum logic {
        IDLE,
        ACTIVE
    } stateT;

    stateT       state;
    logic        start;
    logic        doneReg;
    logic [31:0] rdataReg;

    // A request still high in the done cycle was already served.
    assign start = (state == IDLE) && mem.req && !doneReg;

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= IDLE;
            doneReg <= 1'b0;
        end else begin
            doneReg <= 1'b0;
            if (start) begin
                state <= ACTIVE;
            end else if ((state == ACTIVE) && wbAck) begin
                state   <= IDLE;
                doneReg <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            wbWe   <= mem.we;
            wbAdr  <= mem.addr;
            wbDatW <= mem.wdata;
        end
        if ((state == ACTIVE) && wbAck) begin
            rdataReg <= wbDatR;
        end
    end

    assign wbCyc     = (state == ACTIVE);
    assign wbStb     = (state == ACTIVE);
    assign mem.done  = doneReg;
    assign mem.rdata = rdataReg;

    assert property (@(posedge clk) disable iff (reset) wbStb |-> wbCyc);

    assert property (@(posedge clk) disable iff (reset) wbCyc && !wbAck |=> wbCyc);

    // The core keeps its request steady until done.
    assert property (@(posedge clk) disable iff (reset)
        mem.req && !mem.done |=> mem.req && $stable(mem.addr) && $stable(mem.we));

endmodule

`default_nettype wire

//--- rtl/mipsTop.sv
`default_nettype none

module mipsTop (
    input  logic        clk,
    input  logic        reset,
    output logic [31:0] instrAddr,
    input  logic [31:0] instrData,
    output logic        wbCyc,
    output logic        wbStb,
    output logic        wbWe,
    output logic [31:0] wbAdr,
    output logic [31:0] wbDatW,
    input  logic [31:0] wbDatR,
    input  logic        wbAck
);

    memReqIf memBus ();

    cpuCore core (
        .clk(clk),
        .reset(reset),
        .instrAddr(instrAddr),
        .instrData(instrData),
        .mem(memBus.core)
    );

    wbMaster busMaster (
        .clk(clk),
        .reset(reset),
        .mem(memBus.bus),
        .wbCyc(wbCyc),
        .wbStb(wbStb),
        .wbWe(wbWe),
        .wbAdr(wbAdr),
        .wbDatW(wbDatW),
        .wbDatR(wbDatR),
        .wbAck(wbAck)
    );

endmodule

`default_nettype wire

//--- dv/mipsTb.sv
`default_nettype none

module mipsTb
    import mipsPkg::*;
;

    localparam int          RUN_TIMEOUT = 3000;
    localparam logic [31:0] END_ADDR    = 32'h0000_03fc;

    logic        clk = 1'b0;
    logic        reset = 1'b1;
    logic [31:0] instrAddr;
    logic [31:0] instrData;
    logic        wbCyc;
    logic        wbStb;
    logic        wbWe;
    logic [31:0] wbAdr;
    logic [31:0] wbDatW;
    logic [31:0] wbDatR = '0;
    logic        wbAck = 1'b0;

    logic [31:0] rom [256];
    logic [31:0] ram [256];
    integer      seed = 32'h414f1cce;
    int          waitLeft = 0;
    logic        busy = 1'b0;
    logic [31:0] heldAdr = '0;
    logic        endSeen = 1'b0;

    mipsTop UUT (
        .clk(clk), .reset(reset),
        .instrAddr(instrAddr), .instrData(instrData),
        .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr),
        .wbDatW(wbDatW), .wbDatR(wbDatR), .wbAck(wbAck)
    );

    initial begin
        forever begin
            #10 clk = ~clk;
        end
    end

    // Instruction ROM, read in the same cycle.
    assign instrData = (instrAddr[31:10] == 22'd0) ? rom[instrAddr[9:2]] : 32'd0;

    function automatic logic [31:0] rType(logic [4:0] rs, logic [4:0] rt, logic [4:0] rd,
                                          logic [5:0] funct);
        return {OP_R, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic logic [31:0] iType(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
                                          logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] jType(logic [5:0] op, logic [25:0] index);
        return {op, index};
    endfunction

    function automatic logic [31:0] fillWord(logic [31:0] addr);
        return addr ^ 32'hc3a5_0000;
    endfunction

    function automatic logic [31:0] ramAt(logic [31:0] addr);
        return ram[addr[9:2]];
    endfunction

    task automatic reportFail(input string what);
        $display("%s", what);
        $display("TEST FAILED");
        $fatal(1, "Simulation stopped at the first failure.");
    endtask

    task automatic checkWord(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            reportFail($sformatf("[ERROR] t=%0t %s: got %h, expected %h",
                                 $time, name, got, exp));
        end
    endtask

    task automatic checkBus(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            reportFail($sformatf("[ERROR] t=%0t %s: got %b, expected %b",
                                 $time, name, got, exp));
        end
    endtask

    // Data RAM slave with 0 to 3 random wait states per transfer.
    always @(posedge clk) begin
        #1;
        if (reset) begin
            wbAck = 1'b0;
            busy  = 1'b0;
        end else if (wbAck) begin
            wbAck = 1'b0;
            busy  = 1'b0;
            checkBus("wbCyc after ack", wbCyc, 1'b0);
        end else if (busy && !(wbCyc && wbStb)) begin
            reportFail("Wishbone cyc or stb dropped before the acknowledge.");
        end else if (wbCyc && wbStb) begin
            if (!busy) begin
                busy     = 1'b1;
                heldAdr  = wbAdr;
                waitLeft = $unsigned($random(seed)) % 4;
            end
            checkWord("wbAdr", wbAdr, heldAdr);
            if (waitLeft == 0) begin
                wbAck = 1'b1;
                if (wbWe) begin
                    ram[wbAdr[9:2]] = wbDatW;
                    if (wbAdr == END_ADDR) begin
                        endSeen = 1'b1;
                    end
                end else begin
                    wbDatR = ram[wbAdr[9:2]];
                end
            end else begin
                waitLeft--;
            end
        end
    end

    task automatic clearMemories();
        for (int i = 0; i < 256; i++) begin
            rom[i] = 32'd0;
            ram[i] = fillWord(i * 4);
        end
        endSeen = 1'b0;
    endtask

    task automatic applyReset();
        @(posedge clk);
        #1 reset = 1'b1;
        repeat (10) @(posedge clk);
        #1 reset = 1'b0;
    endtask

    task automatic runUntilEnd(input string testName);
        int cycles;
        cycles = 0;
        while (!endSeen && cycles < RUN_TIMEOUT) begin
            @(posedge clk);
            #2;
            cycles++;
        end
        if (!endSeen) begin
            reportFail($sformatf("%s timed out waiting for the final store.", testName));
        end
    endtask

    task automatic resetTest();
        clearMemories();
        applyReset();
        checkBus("wbCyc", wbCyc, 1'b0);
        checkBus("wbStb", wbStb, 1'b0);
        checkWord("instrAddr", instrAddr, RESET_PC);
    endtask

    task automatic aluTest();
        logic [31:0] r1, r2, r3, r4;
        clearMemories();
        rom[0] = iType(OP_LUI, 5'd0, 5'd1, 16'h1234);
        rom[1] = iType(OP_ORI, 5'd1, 5'd1, 16'h8765);
        rom[2] = iType(OP_ORI, 5'd0, 5'd2, 16'h00ff);
        rom[3] = rType(5'd1, 5'd2, 5'd3, FUNC_ADD);
        rom[4] = rType(5'd2, 5'd1, 5'd4, FUNC_SUB);
        rom[5] = iType(OP_ORI, 5'd0, 5'd5, 16'h0200);
        rom[6] = iType(OP_SW, 5'd5, 5'd1, 16'h0000);
        rom[7] = iType(OP_SW, 5'd5, 5'd3, 16'h0004);
        rom[8] = iType(OP_SW, 5'd5, 5'd4, 16'hfffc);
        rom[9] = iType(OP_SW, 5'd0, 5'd2, END_ADDR[15:0]);
        applyReset();
        runUntilEnd("ALU test");
        // ori zero-extends, so the upper half survives.
        r1 = 32'h1234_0000 | 32'h0000_8765;
        r2 = 32'h0000_00ff;
        r3 = r1 + r2;
        r4 = r2 - r1;
        checkWord("ram[0x200]", ramAt(32'h200), r1);
        checkWord("ram[0x204]", ramAt(32'h204), r3);
        checkWord("ram[0x1fc]", ramAt(32'h1fc), r4);
        checkWord("ram[end]", ramAt(END_ADDR), r2);
    endtask

    task automatic forwardTest();
        logic [31:0] r1, r2, r3, r4, r6, r9;
        clearMemories();
        rom[0]  = iType(OP_ORI, 5'd0, 5'd1, 16'd5);
        rom[1]  = rType(5'd1, 5'd1, 5'd2, FUNC_ADD);
        rom[2]  = rType(5'd2, 5'd1, 5'd3, FUNC_ADD);
        rom[3]  = rType(5'd3, 5'd2, 5'd4, FUNC_SUB);
        rom[4]  = iType(OP_LW, 5'd0, 5'd5, 16'h0100);
        rom[5]  = rType(5'd5, 5'd4, 5'd6, FUNC_ADD);
        rom[6]  = iType(OP_SW, 5'd0, 5'd6, 16'h0204);
        rom[7]  = iType(OP_LW, 5'd0, 5'd7, 16'h0104);
        rom[8]  = iType(OP_SW, 5'd0, 5'd7, 16'h0208);
        rom[9]  = iType(OP_LW, 5'd0, 5'd8, 16'h0108);
        rom[10] = iType(OP_ORI, 5'd8, 5'd9, 16'h000f);
        rom[11] = iType(OP_SW, 5'd0, 5'd9, 16'h020c);
        rom[12] = iType(OP_SW, 5'd0, 5'd3, END_ADDR[15:0]);
        applyReset();
        runUntilEnd("Forwarding test");
        r1 = 32'd5;
        r2 = r1 + r1;
        r3 = r2 + r1;
        r4 = r3 - r2;
        r6 = fillWord(32'h100) + r4;
        r9 = fillWord(32'h108) | 32'h0000_000f;
        checkWord("ram[0x204]", ramAt(32'h204), r6);
        checkWord("ram[0x208]", ramAt(32'h208), fillWord(32'h104));
        checkWord("ram[0x20c]", ramAt(32'h20c), r9);
        checkWord("ram[end]", ramAt(END_ADDR), r3);
    endtask

    task automatic branchTest();
        clearMemories();
        rom[0]  = iType(OP_ORI, 5'd0, 5'd1, 16'd7);
        rom[1]  = iType(OP_ORI, 5'd0, 5'd2, 16'd7);
        rom[2]  = iType(OP_ORI, 5'd0, 5'd3, 16'd9);
        rom[3]  = iType(OP_BEQ, 5'd1, 5'd2, 16'd3);
        rom[4]  = iType(OP_ORI, 5'd0, 5'd4, 16'h0011);
        rom[5]  = iType(OP_ORI, 5'd0, 5'd5, 16'h0bad);
        rom[6]  = iType(OP_SW, 5'd0, 5'd5, 16'h0300);
        rom[7]  = iType(OP_BEQ, 5'd1, 5'd3, 16'd3);
        rom[8]  = iType(OP_ORI, 5'd0, 5'd6, 16'h0022);
        rom[9]  = iType(OP_ORI, 5'd0, 5'd7, 16'h0033);
        rom[10] = iType(OP_SW, 5'd0, 5'd5, 16'h0304);
        rom[11] = iType(OP_SW, 5'd0, 5'd4, 16'h0308);
        rom[12] = iType(OP_SW, 5'd0, 5'd6, 16'h030c);
        rom[13] = iType(OP_SW, 5'd0, 5'd7, 16'h0310);
        rom[14] = iType(OP_SW, 5'd0, 5'd2, END_ADDR[15:0]);
        applyReset();
        runUntilEnd("Branch test");
        // Skipped code leaves r5 at zero and 0x300 untouched.
        checkWord("ram[0x300]", ramAt(32'h300), fillWord(32'h300));
        checkWord("ram[0x304]", ramAt(32'h304), 32'd0);
        checkWord("ram[0x308]", ramAt(32'h308), 32'h0000_0011);
        checkWord("ram[0x30c]", ramAt(32'h30c), 32'h0000_0022);
        checkWord("ram[0x310]", ramAt(32'h310), 32'h0000_0033);
        checkWord("ram[end]", ramAt(END_ADDR), 32'd7);
    endtask

    task automatic jalTest();
        logic [31:0] jalAddr;
        clearMemories();
        jalAddr = 32'd4;
        rom[0]  = iType(OP_ORI, 5'd0, 5'd1, 16'd1);
        rom[1]  = jType(OP_JAL, 26'd9);
        rom[2]  = iType(OP_ORI, 5'd0, 5'd2, 16'd2);
        rom[3]  = iType(OP_SW, 5'd0, 5'd31, 16'h0380);
        rom[4]  = iType(OP_SW, 5'd0, 5'd3, 16'h0384);
        rom[5]  = iType(OP_SW, 5'd0, 5'd2, 16'h0388);
        rom[6]  = iType(OP_SW, 5'd0, 5'd4, 16'h038c);
        rom[7]  = iType(OP_SW, 5'd0, 5'd1, END_ADDR[15:0]);
        rom[9]  = iType(OP_ORI, 5'd0, 5'd3, 16'h0055);
        rom[10] = rType(5'd31, 5'd0, 5'd0, FUNC_JR);
        rom[11] = iType(OP_ORI, 5'd0, 5'd4, 16'h0066);
        applyReset();
        runUntilEnd("Jump test");
        checkWord("ram[0x380]", ramAt(32'h380), jalAddr + 32'd8);
        checkWord("ram[0x384]", ramAt(32'h384), 32'h0000_0055);
        checkWord("ram[0x388]", ramAt(32'h388), 32'd2);
        checkWord("ram[0x38c]", ramAt(32'h38c), 32'h0000_0066);
        checkWord("ram[end]", ramAt(END_ADDR), 32'd1);
    endtask

    initial begin
        resetTest();
        aluTest();
        forwardTest();
        branchTest();
        jalTest();
        // Same programs again, with fresh wait states.
        forwardTest();
        aluTest();
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
rtl/mipsPkg.sv
rtl/memReqIf.sv
rtl/ctrlDecode.sv
rtl/regFile.sv
rtl/hazardUnit.sv
rtl/pipeReg.sv
rtl/cpuCore.sv
rtl/wbMaster.sv
rtl/mipsTop.sv
dv/mipsTb.sv
